// ==== src/disc_consts.svh ====
// sizing constants for the sample discriminator.
// channel count, batch geometry, hold timer and timestamp widths.
`ifndef DISC_CONSTS_SVH
`define DISC_CONSTS_SVH

`define DISC_CHANNELS 2
`define DISC_PARALLEL 2
`define DISC_SAMPLE_WIDTH 16
`define DISC_TIMER_BITS 6
`define DISC_TSTAMP_WIDTH 32

// derived sizes.
`define DISC_BATCH_WIDTH (`DISC_PARALLEL * `DISC_SAMPLE_WIDTH)
`define DISC_CHAN_BITS ($clog2(`DISC_CHANNELS))

`endif

// ==== src/disc_pkg.sv ====
// shared types for the sample discriminator.
// configuration opcodes and gate FSM states.
`default_nettype none
`include "disc_consts.svh"

package disc_pkg;

  // opcode of a configuration write.
  typedef enum logic [1:0] {
    OP_THRESH  = 2'd0,
    OP_HOLD    = 2'd1,
    OP_SOURCE  = 2'd2,
    OP_DISABLE = 2'd3
  } cfg_op_e;

  // per-channel gate state.
  typedef enum logic [1:0] {
    GATE_IDLE = 2'd0,
    GATE_OPEN = 2'd1,
    GATE_HOLD = 2'd2
  } gate_state_e;

endpackage

`default_nettype wire

// ==== src/disc_config_regs.sv ====
// configuration register block of the sample discriminator.
// valid/ready write port decoding thresholds, hold counts,
// trigger sources and the disable mask.
`default_nettype none
`include "disc_consts.svh"

module disc_config_regs
  import disc_pkg::*;
(
  input  logic                                            adc_clk,
  input  logic                                            rst_i,
  input  logic                                            cfg_valid_i,
  input  cfg_op_e                                         cfg_op_i,
  input  logic [`DISC_CHAN_BITS-1:0]                      cfg_chan_i,
  input  logic [31:0]                                     cfg_data_i,
  output logic                                            cfg_ready_o,
  output logic [`DISC_CHANNELS*`DISC_SAMPLE_WIDTH-1:0]    low_thresh_o,
  output logic [`DISC_CHANNELS*`DISC_SAMPLE_WIDTH-1:0]    high_thresh_o,
  output logic [`DISC_CHANNELS*`DISC_TIMER_BITS-1:0]      hold_count_o,
  output logic [`DISC_CHANNELS*`DISC_CHAN_BITS-1:0]       trig_source_o,
  output logic [`DISC_CHANNELS-1:0]                       disable_mask_o
);

  localparam int CH        = `DISC_CHANNELS;
  localparam int SW        = `DISC_SAMPLE_WIDTH;
  localparam int TB        = `DISC_TIMER_BITS;
  localparam int CHAN_BITS = `DISC_CHAN_BITS;

  logic [CH-1:0][SW-1:0]        low_q;
  logic [CH-1:0][SW-1:0]        high_q;
  logic [CH-1:0][TB-1:0]        hold_q;
  logic [CH-1:0][CHAN_BITS-1:0] src_q;
  logic [CH-1:0]                mask_q;
  logic                         ready_q;
  logic                         wr_en;

  assign wr_en          = cfg_valid_i & ready_q;
  assign cfg_ready_o    = ready_q;
  assign low_thresh_o   = low_q;
  assign high_thresh_o  = high_q;
  assign hold_count_o   = hold_q;
  assign trig_source_o  = src_q;
  assign disable_mask_o = mask_q;

  // ready comes up one cycle after reset is released.
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int ch = 0; ch < CH; ch++) begin
        low_q[ch]  <= '0;
        high_q[ch] <= {1'b0, {(SW-1){1'b1}}};
        hold_q[ch] <= '0;
        // each channel triggers on its own level by default.
        src_q[ch]  <= CHAN_BITS'(ch);
      end
      mask_q <= '0;
    end else if (wr_en) begin
      case (cfg_op_i)
        OP_THRESH: begin
          high_q[cfg_chan_i] <= cfg_data_i[2*SW-1:SW];
          low_q[cfg_chan_i]  <= cfg_data_i[SW-1:0];
        end
        OP_HOLD: begin
          hold_q[cfg_chan_i] <= cfg_data_i[TB-1:0];
        end
        OP_SOURCE: begin
          src_q[cfg_chan_i] <= cfg_data_i[CHAN_BITS-1:0];
        end
        OP_DISABLE: begin
          // channel field is don't care here.
          mask_q <= cfg_data_i[CH-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // no handshake may complete while the block is in reset.
  a_no_write_in_reset: assert property (
    @(posedge adc_clk) rst_i |-> !(cfg_valid_i && cfg_ready_o)
  );

endmodule

`default_nettype wire

// ==== src/level_detector.sv ====
// hysteresis level detector for one ADC channel.
// registers the batch and its valid beside the level flag.
`default_nettype none
`include "disc_consts.svh"

module level_detector (
  input  logic                          adc_clk,
  input  logic                          rst_i,
  input  logic [`DISC_BATCH_WIDTH-1:0]  batch_i,
  input  logic                          valid_i,
  input  logic [`DISC_SAMPLE_WIDTH-1:0] low_thresh_i,
  input  logic [`DISC_SAMPLE_WIDTH-1:0] high_thresh_i,
  output logic [`DISC_BATCH_WIDTH-1:0]  batch_o,
  output logic                          valid_o,
  output logic                          level_o
);

  localparam int SW  = `DISC_SAMPLE_WIDTH;
  localparam int PAR = `DISC_PARALLEL;

  logic any_high;
  logic all_low;

  // signed compare of every sample against both thresholds.
  always_comb begin
    any_high = 1'b0;
    all_low  = 1'b1;
    for (int i = 0; i < PAR; i++) begin
      if ($signed(batch_i[i*SW +: SW]) >= $signed(high_thresh_i)) begin
        any_high = 1'b1;
      end
      if ($signed(batch_i[i*SW +: SW]) >= $signed(low_thresh_i)) begin
        all_low = 1'b0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      level_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        // set wins over clear when thresholds overlap.
        if (any_high) begin
          level_o <= 1'b1;
        end else if (all_low) begin
          level_o <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    batch_o <= batch_i;
  end

endmodule

`default_nettype wire

// ==== src/sample_gate.sv ====
// per-channel gate of the sample discriminator.
// trigger select, gate FSM with hold-off counter, burst-start timestamp.
`default_nettype none
`include "disc_consts.svh"

module sample_gate
  import disc_pkg::*;
(
  input  logic                          adc_clk,
  input  logic                          rst_i,
  input  logic [`DISC_BATCH_WIDTH-1:0]  batch_i,
  input  logic                          valid_i,
  input  logic [`DISC_CHANNELS-1:0]     levels_i,
  input  logic [`DISC_TSTAMP_WIDTH-1:0] tstamp_i,
  input  logic [`DISC_CHAN_BITS-1:0]    trig_source_i,
  input  logic [`DISC_TIMER_BITS-1:0]   hold_count_i,
  input  logic                          disable_i,
  output logic [`DISC_BATCH_WIDTH-1:0]  data_o,
  output logic                          data_valid_o,
  output logic [`DISC_TSTAMP_WIDTH-1:0] tstamp_o,
  output logic                          tstamp_valid_o
);

  localparam int TB = `DISC_TIMER_BITS;

  gate_state_e   state_q;
  gate_state_e   state_d;
  logic [TB-1:0] remain_q;
  logic [TB-1:0] remain_d;
  logic          trig;
  logic          pass;
  logic          start;

  assign trig = levels_i[trig_source_i];

  always_comb begin
    state_d  = state_q;
    remain_d = remain_q;
    pass     = 1'b0;
    start    = 1'b0;
    if (valid_i) begin
      if (disable_i) begin
        // discrimination off, everything goes through.
        pass    = 1'b1;
        state_d = GATE_IDLE;
      end else begin
        case (state_q)
          GATE_IDLE: begin
            if (trig) begin
              pass    = 1'b1;
              start   = 1'b1;
              state_d = GATE_OPEN;
            end
          end
          GATE_OPEN: begin
            if (trig) begin
              pass = 1'b1;
            end else if (hold_count_i == '0) begin
              state_d = GATE_IDLE;
            end else begin
              pass     = 1'b1;
              remain_d = hold_count_i - 1'b1;
              state_d  = GATE_HOLD;
            end
          end
          GATE_HOLD: begin
            if (trig) begin
              // re-trigger, same burst so no new timestamp.
              pass    = 1'b1;
              state_d = GATE_OPEN;
            end else if (remain_q != '0) begin
              pass     = 1'b1;
              remain_d = remain_q - 1'b1;
            end else begin
              state_d = GATE_IDLE;
            end
          end
          default: begin
            state_d = GATE_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q        <= GATE_IDLE;
      remain_q       <= '0;
      data_valid_o   <= 1'b0;
      tstamp_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      remain_q       <= remain_d;
      data_valid_o   <= pass;
      tstamp_valid_o <= start;
    end
  end

  // payload only moves when something is sent.
  always_ff @(posedge adc_clk) begin
    if (pass) begin
      data_o <= batch_i;
    end
    if (start) begin
      tstamp_o <= tstamp_i;
    end
  end

  a_tstamp_with_data: assert property (
    @(posedge adc_clk) disable iff (rst_i)
    tstamp_valid_o |-> data_valid_o
  );

  // an exhausted hold never wraps around.
  a_hold_no_underflow: assert property (
    @(posedge adc_clk) disable iff (rst_i)
    (state_q == GATE_HOLD && remain_q == '0) |=> remain_q == '0
  );

endmodule

`default_nettype wire

// ==== src/sample_discriminator.sv ====
// top level of the sample discriminator.
// config block, free-running sample counter, per-channel detectors and gates.
`default_nettype none
`include "disc_consts.svh"

module sample_discriminator
  import disc_pkg::*;
(
  input  logic                                          adc_clk,
  input  logic                                          rst_i,
  input  logic                                          cfg_valid_i,
  input  cfg_op_e                                       cfg_op_i,
  input  logic [`DISC_CHAN_BITS-1:0]                    cfg_chan_i,
  input  logic [31:0]                                   cfg_data_i,
  input  logic [`DISC_CHANNELS*`DISC_BATCH_WIDTH-1:0]   adc_data_i,
  input  logic [`DISC_CHANNELS-1:0]                     adc_valid_i,
  output logic                                          cfg_ready_o,
  output logic [`DISC_CHANNELS*`DISC_BATCH_WIDTH-1:0]   data_o,
  output logic [`DISC_CHANNELS-1:0]                     data_valid_o,
  output logic [`DISC_CHANNELS*`DISC_TSTAMP_WIDTH-1:0]  tstamp_o,
  output logic [`DISC_CHANNELS-1:0]                     tstamp_valid_o
);

  localparam int CH        = `DISC_CHANNELS;
  localparam int SW        = `DISC_SAMPLE_WIDTH;
  localparam int BW        = `DISC_BATCH_WIDTH;
  localparam int TB        = `DISC_TIMER_BITS;
  localparam int TSW       = `DISC_TSTAMP_WIDTH;
  localparam int CHAN_BITS = `DISC_CHAN_BITS;

  logic [CH*SW-1:0]        low_thresh;
  logic [CH*SW-1:0]        high_thresh;
  logic [CH*TB-1:0]        hold_count;
  logic [CH*CHAN_BITS-1:0] trig_source;
  logic [CH-1:0]           disable_mask;
  logic [CH-1:0]           levels;
  logic [TSW-1:0]          sample_count_q;
  logic [TSW-1:0]          sample_count_d1;

  disc_config_regs u_cfg (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .cfg_valid_i    (cfg_valid_i),
    .cfg_op_i       (cfg_op_i),
    .cfg_chan_i     (cfg_chan_i),
    .cfg_data_i     (cfg_data_i),
    .cfg_ready_o    (cfg_ready_o),
    .low_thresh_o   (low_thresh),
    .high_thresh_o  (high_thresh),
    .hold_count_o   (hold_count),
    .trig_source_o  (trig_source),
    .disable_mask_o (disable_mask)
  );

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sample_count_q <= '0;
    end else begin
      sample_count_q <= sample_count_q + 1'b1;
    end
  end

  // lines the count up with the detector output.
  always_ff @(posedge adc_clk) begin
    sample_count_d1 <= sample_count_q;
  end

  for (genvar ch = 0; ch < CH; ch++) begin : g_chan
    logic [BW-1:0] det_batch;
    logic          det_valid;

    level_detector u_det (
      .adc_clk       (adc_clk),
      .rst_i         (rst_i),
      .batch_i       (adc_data_i[ch*BW +: BW]),
      .valid_i       (adc_valid_i[ch]),
      .low_thresh_i  (low_thresh[ch*SW +: SW]),
      .high_thresh_i (high_thresh[ch*SW +: SW]),
      .batch_o       (det_batch),
      .valid_o       (det_valid),
      .level_o       (levels[ch])
    );

    sample_gate u_gate (
      .adc_clk        (adc_clk),
      .rst_i          (rst_i),
      .batch_i        (det_batch),
      .valid_i        (det_valid),
      .levels_i       (levels),
      .tstamp_i       (sample_count_d1),
      .trig_source_i  (trig_source[ch*CHAN_BITS +: CHAN_BITS]),
      .hold_count_i   (hold_count[ch*TB +: TB]),
      .disable_i      (disable_mask[ch]),
      .data_o         (data_o[ch*BW +: BW]),
      .data_valid_o   (data_valid_o[ch]),
      .tstamp_o       (tstamp_o[ch*TSW +: TSW]),
      .tstamp_valid_o (tstamp_valid_o[ch])
    );
  end

endmodule

`default_nettype wire

// ==== verif/sample_discriminator_tb.sv ====
// testbench for the sample discriminator.
// random batches, reference model of the level and gate rules, output compare.
`default_nettype none
`include "disc_consts.svh"

module sample_discriminator_tb
  import disc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CH  = `DISC_CHANNELS;
  localparam int PAR = `DISC_PARALLEL;
  localparam int SW  = `DISC_SAMPLE_WIDTH;
  localparam int BW  = `DISC_BATCH_WIDTH;
  localparam int TSW = `DISC_TSTAMP_WIDTH;
  localparam int CHB = `DISC_CHAN_BITS;
  localparam int S_IDLE = 0;
  localparam int S_OPEN = 1;
  localparam int S_HOLD = 2;
  localparam int N_CFG = 10;
  localparam int N_STREAM = 40 + 80 + 80 + 60 + 60;
  localparam int MAX_CYCLES = 2 + 1 + N_CFG + N_STREAM + 4 + 50;

  logic              adc_clk;
  logic              rst_i;
  logic              cfg_valid_i;
  cfg_op_e           cfg_op_i;
  logic [CHB-1:0]    cfg_chan_i;
  logic [31:0]       cfg_data_i;
  logic [CH*BW-1:0]  adc_data_i;
  logic [CH-1:0]     adc_valid_i;
  logic              cfg_ready_o;
  logic [CH*BW-1:0]  data_o;
  logic [CH-1:0]     data_valid_o;
  logic [CH*TSW-1:0] tstamp_o;
  logic [CH-1:0]     tstamp_valid_o;

  // reference model state and config mirror.
  logic [CH-1:0]        m_level;
  logic [CH-1:0]        m_dis;
  int                   m_state[CH];
  int                   m_remain[CH];
  int                   m_hold[CH];
  int                   m_src[CH];
  logic signed [SW-1:0] m_low[CH];
  logic signed [SW-1:0] m_high[CH];

  logic [CH-1:0]    exp_dv_q[$];
  logic [CH-1:0]    exp_tv_q[$];
  logic [CH*BW-1:0] exp_data_q[$];
  logic [TSW-1:0]   exp_ts_q[$];

  integer         seed;
  logic [TSW-1:0] tb_count;
  int             errors;
  int             checks;
  int             cycles;

  sample_discriminator dut (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .cfg_valid_i    (cfg_valid_i),
    .cfg_op_i       (cfg_op_i),
    .cfg_chan_i     (cfg_chan_i),
    .cfg_data_i     (cfg_data_i),
    .adc_data_i     (adc_data_i),
    .adc_valid_i    (adc_valid_i),
    .cfg_ready_o    (cfg_ready_o),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o),
    .tstamp_o       (tstamp_o),
    .tstamp_valid_o (tstamp_valid_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // one batch per channel through the level rule, then the gate rule.
  function automatic void predict(input logic [CH*BW-1:0] data, input logic [CH-1:0] valid,
                                  output logic [CH-1:0] pass, output logic [CH-1:0] start);
    logic signed [SW-1:0] s;
    logic                 any_high;
    logic                 all_low;
    logic                 trig;
    pass  = '0;
    start = '0;
    // all flags first, a gate may watch another channel.
    for (int ch = 0; ch < CH; ch++) begin
      if (valid[ch]) begin
        any_high = 1'b0;
        all_low  = 1'b1;
        for (int i = 0; i < PAR; i++) begin
          s = data[ch*BW + i*SW +: SW];
          if (s >= m_high[ch]) any_high = 1'b1;
          if (s >= m_low[ch]) all_low = 1'b0;
        end
        if (any_high) m_level[ch] = 1'b1;
        else if (all_low) m_level[ch] = 1'b0;
      end
    end
    for (int ch = 0; ch < CH; ch++) begin
      trig = m_level[m_src[ch]];
      if (valid[ch] && m_dis[ch]) begin
        pass[ch]    = 1'b1;
        m_state[ch] = S_IDLE;
      end else if (valid[ch]) begin
        if (m_state[ch] == S_IDLE) begin
          pass[ch]    = trig;
          start[ch]   = trig;
          m_state[ch] = trig ? S_OPEN : S_IDLE;
        end else if (trig) begin
          pass[ch]    = 1'b1;
          m_state[ch] = S_OPEN;
        end else if (m_state[ch] == S_OPEN && m_hold[ch] != 0) begin
          pass[ch]     = 1'b1;
          m_remain[ch] = m_hold[ch] - 1;
          m_state[ch]  = S_HOLD;
        end else if (m_state[ch] == S_HOLD && m_remain[ch] != 0) begin
          pass[ch]     = 1'b1;
          m_remain[ch] = m_remain[ch] - 1;
        end else begin
          m_state[ch] = S_IDLE;
        end
      end
    end
  endfunction

  // predict the current inputs, then advance to 2 ns after the next edge.
  task automatic step();
    logic [CH-1:0] pass;
    logic [CH-1:0] start;
    predict(adc_data_i, adc_valid_i, pass, start);
    exp_dv_q.push_back(pass);
    exp_tv_q.push_back(start);
    exp_data_q.push_back(adc_data_i);
    exp_ts_q.push_back(tb_count);
    tb_count++;
    @(posedge adc_clk);
    #2;
  endtask

  task automatic write_cfg(input cfg_op_e op, input int chan, input logic [31:0] data);
    logic accepted;
    int   took;
    took        = 0;
    cfg_valid_i = 1'b1;
    cfg_op_i    = op;
    cfg_chan_i  = CHB'(chan);
    cfg_data_i  = data;
    do begin
      accepted = cfg_ready_o;
      step();
      took++;
    end while (!accepted);
    cfg_valid_i = 1'b0;
    check("cfg_write_cycles", 1, took);
    case (op)
      OP_THRESH: begin
        m_high[chan] = data[31:16];
        m_low[chan]  = data[15:0];
      end
      OP_HOLD:    m_hold[chan] = int'(data[`DISC_TIMER_BITS-1:0]);
      OP_SOURCE:  m_src[chan] = int'(data[CHB-1:0]);
      default:    m_dis = data[CH-1:0];
    endcase
  endtask

  // samples in [-span, span], valid kept with probability keep/8.
  task automatic run_stream(input int n, input int span, input int keep);
    for (int k = 0; k < n; k++) begin
      for (int ch = 0; ch < CH; ch++) begin
        adc_valid_i[ch] = (($random(seed) & 7) < keep);
        for (int i = 0; i < PAR; i++) begin
          adc_data_i[ch*BW + i*SW +: SW] = 16'($random(seed) % (span + 1));
        end
      end
      step();
    end
    adc_valid_i = '0;
  endtask

  always @(negedge adc_clk) begin
    logic [CH-1:0]    dv;
    logic [CH-1:0]    tv;
    logic [CH*BW-1:0] data;
    logic [TSW-1:0]   ts;
    if (exp_dv_q.size() > 2) begin
      dv   = exp_dv_q.pop_front();
      tv   = exp_tv_q.pop_front();
      data = exp_data_q.pop_front();
      ts   = exp_ts_q.pop_front();
      for (int ch = 0; ch < CH; ch++) begin
        check($sformatf("data_valid_o[%0d]", ch), dv[ch], data_valid_o[ch]);
        check($sformatf("tstamp_valid_o[%0d]", ch), tv[ch], tstamp_valid_o[ch]);
        if (dv[ch]) check($sformatf("data_o[%0d]", ch), data[ch*BW +: BW], data_o[ch*BW +: BW]);
        if (tv[ch]) check($sformatf("tstamp_o[%0d]", ch), ts, tstamp_o[ch*TSW +: TSW]);
      end
    end
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    seed = 32'h7e28_73db;
    rst_i = 1'b1;
    cfg_valid_i = 1'b0;
    cfg_op_i = OP_THRESH;
    cfg_chan_i = '0;
    cfg_data_i = '0;
    adc_data_i = '0;
    adc_valid_i = '0;
    tb_count = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    m_level = '0;
    m_dis = '0;
    for (int ch = 0; ch < CH; ch++) begin
      m_state[ch] = S_IDLE;
      m_remain[ch] = 0;
      m_hold[ch] = 0;
      m_src[ch] = ch;
      m_low[ch] = '0;
      m_high[ch] = 16'h7fff;
    end
    repeat (2) @(posedge adc_clk);
    #2;
    rst_i = 1'b0;
    check("cfg_ready_o", 0, cfg_ready_o);
    check("data_valid_o", 0, data_valid_o);
    check("tstamp_valid_o", 0, tstamp_valid_o);
    step();
    check("cfg_ready_o", 1, cfg_ready_o);
    // every opcode once, both channels disabled.
    write_cfg(OP_DISABLE, 0, 32'h3);
    write_cfg(OP_THRESH, 0, {16'(1200), 16'(200)});
    write_cfg(OP_THRESH, 1, {16'(500), 16'(-500)});
    write_cfg(OP_HOLD, 0, 32'd0);
    write_cfg(OP_SOURCE, 1, 32'd1);
    run_stream(40, 2000, 6);
    write_cfg(OP_DISABLE, 0, 32'h0);
    run_stream(80, 2000, 6);
    write_cfg(OP_HOLD, 0, 32'd3);
    write_cfg(OP_HOLD, 1, 32'd5);
    run_stream(80, 2000, 6);
    // channel 1 follows channel 0.
    write_cfg(OP_SOURCE, 1, 32'd0);
    run_stream(60, 2000, 6);
    write_cfg(OP_SOURCE, 1, 32'd1);
    run_stream(60, 2000, 3);
    repeat (4) step();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/disc_pkg.sv
src/disc_config_regs.sv
src/level_detector.sv
src/sample_gate.sv
src/sample_discriminator.sv
verif/sample_discriminator_tb.sv

// ==== Makefile ====
# Verilator simulation of the sample discriminator.
TOP := sample_discriminator_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator, then check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f sim.f --Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
